// ==== source/lock_pkg.sv ====
package lock_pkg;

    // kinds of decoded key press
    typedef enum logic [1:0] {
        KEY_DIGIT  = 2'd0,
        KEY_ENTER  = 2'd1,
        KEY_CANCEL = 2'd2,
        KEY_CLEAR  = 2'd3
    } key_kind_e;

    // one decoded key press, valid for a single cycle
    typedef struct packed {
        logic      valid;
        key_kind_e kind;
        logic [3:0] digit;  // only meaningful for KEY_DIGIT
    } key_event_t;

    typedef enum logic [1:0] {
        TONE_CLICK   = 2'd0,
        TONE_SUCCESS = 2'd1,
        TONE_FAIL    = 2'd2
    } tone_kind_e;

    // start request for the buzzer, replaces any running tone
    typedef struct packed {
        logic       valid;
        tone_kind_e kind;
    } tone_req_t;

    typedef enum logic [1:0] {
        ST_ENTRY  = 2'd0,
        ST_OPEN   = 2'd1,
        ST_LOCKED = 2'd2
    } lock_state_e;

    localparam logic [3:0]  BLANK_NIBBLE = 4'hF;    // dark digit
    localparam logic [11:0] OPEN_GLYPH   = 12'hBCC; // shown while open

    localparam int CODE_DIGITS = 3;
    localparam int TRY_W       = 3;

endpackage

// ==== source/key_decoder.sv ====
`timescale 1ns/1ps

module key_decoder import lock_pkg::*; (
    input  logic        clk,
    input  logic        arst_n,
    input  logic [15:0] onehot,
    output key_event_t  key
);

    logic [15:0] onehot_q;  // keypad sampled once
    logic [15:0] prev_q;    // value seen one cycle earlier
    key_event_t  dec;       // decode of onehot_q, valid means legal code

    always_comb begin
        dec = '{valid: 1'b1, kind: KEY_DIGIT, digit: 4'h0};
        case (onehot_q)
            16'h0008: dec.digit = 4'd0;
            16'h0080: dec.digit = 4'd1;
            16'h0040: dec.digit = 4'd2;
            16'h0020: dec.digit = 4'd3;
            16'h0800: dec.digit = 4'd4;
            16'h0400: dec.digit = 4'd5;
            16'h0200: dec.digit = 4'd6;
            16'h8000: dec.digit = 4'd7;
            16'h4000: dec.digit = 4'd8;
            16'h2000: dec.digit = 4'd9;
            16'h0001: dec.kind  = KEY_ENTER;
            16'h1000: dec.kind  = KEY_CANCEL;
            16'h0100: dec.kind  = KEY_CLEAR;
            default:  dec.valid = 1'b0;  // release, unused keys, chords
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            onehot_q <= '0;
            prev_q   <= '0;
            key      <= '0;
        end else begin
            onehot_q  <= onehot;
            prev_q    <= onehot_q;
            key.valid <= dec.valid && (onehot_q != prev_q);  // only on a fresh code
            key.kind  <= dec.kind;
            key.digit <= dec.digit;
        end
    end

    // a press produces exactly one strobe, never back to back
    assert property (@(posedge clk) disable iff (!arst_n)
        key.valid |=> !key.valid)
        else $error("key_decoder: key strobe high two cycles in a row");

endmodule

// ==== source/code_entry.sv ====
`timescale 1ns/1ps

module code_entry import lock_pkg::*; #(
    parameter logic [11:0] SECRET    = 12'h246,
    parameter int          MAX_TRIES = 3
) (
    input  logic             clk,
    input  logic             arst_n,
    input  key_event_t       key,
    input  logic [7:0]       secs_left,
    input  logic             lock_done,
    output logic [11:0]      display,
    output lock_state_e      state,
    output logic [TRY_W-1:0] tries,
    output logic             lock_start,
    output tone_req_t        tone
);

    localparam int CNT_W = $clog2(CODE_DIGITS + 1);
    localparam logic [11:0] BLANK = {3{BLANK_NIBBLE}};

    logic [11:0]      entry;  // digits typed so far, newest in low nibble
    logic [CNT_W-1:0] cnt;    // number of digits held

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state      <= ST_ENTRY;
            entry      <= BLANK;
            cnt        <= '0;
            tries      <= '0;
            lock_start <= 1'b0;
            tone       <= '0;
        end else begin
            lock_start <= 1'b0;
            tone.valid <= 1'b0;
            case (state)
                ST_ENTRY: begin
                    if (key.valid) begin
                        case (key.kind)
                            KEY_DIGIT: begin
                                if (cnt < CNT_W'(CODE_DIGITS)) begin
                                    entry <= {entry[7:0], key.digit};
                                    cnt   <= cnt + 1'b1;
                                    tone  <= '{valid: 1'b1, kind: TONE_CLICK};
                                end
                            end
                            KEY_ENTER: begin
                                if (cnt == CNT_W'(CODE_DIGITS)) begin  // short entry ignored
                                    cnt <= '0;
                                    if (entry == SECRET) begin
                                        state <= ST_OPEN;
                                        entry <= OPEN_GLYPH;
                                        tone  <= '{valid: 1'b1, kind: TONE_SUCCESS};
                                    end else begin
                                        entry <= BLANK;
                                        tone  <= '{valid: 1'b1, kind: TONE_FAIL};
                                        if (tries == TRY_W'(MAX_TRIES - 1)) begin
                                            state      <= ST_LOCKED;
                                            tries      <= '0;
                                            lock_start <= 1'b1;
                                        end else begin
                                            tries <= tries + 1'b1;
                                        end
                                    end
                                end
                            end
                            KEY_CANCEL: begin
                                entry <= BLANK;  // tries kept
                                cnt   <= '0;
                            end
                            KEY_CLEAR: begin
                                entry <= BLANK;
                                cnt   <= '0;
                                tries <= '0;
                            end
                            default: ;
                        endcase
                    end
                end
                ST_OPEN: begin
                    if (key.valid && key.kind == KEY_CLEAR) begin  // only clear leaves open
                        state <= ST_ENTRY;
                        entry <= BLANK;
                        cnt   <= '0;
                        tries <= '0;
                    end
                end
                ST_LOCKED: begin
                    if (lock_done) begin  // keys are dropped until here
                        state <= ST_ENTRY;
                        entry <= BLANK;
                        cnt   <= '0;
                    end
                end
                default: state <= ST_ENTRY;
            endcase
        end
    end

    // countdown replaces the entry while locked
    assign display = (state == ST_LOCKED) ? {4'h0, secs_left} : entry;

    // held digits are the non-blank nibbles of the entry
    assert property (@(posedge clk) disable iff (!arst_n)
        state == ST_ENTRY |-> int'(cnt) == (entry[3:0] != BLANK_NIBBLE)
                                         + (entry[7:4] != BLANK_NIBBLE)
                                         + (entry[11:8] != BLANK_NIBBLE))
        else $error("code_entry: digit count does not match the held digits");

endmodule

// ==== source/lockout_timer.sv ====
`timescale 1ns/1ps

module lockout_timer #(
    parameter int LOCK_SECS = 12,
    parameter int TICK_DIV  = 50_000_000
) (
    input  logic       clk,
    input  logic       arst_n,
    input  logic       lock_start,
    output logic [7:0] secs_left,
    output logic       lock_done
);

    localparam int DIV_W = (TICK_DIV > 1) ? $clog2(TICK_DIV) : 1;
    localparam logic [7:0] LOCK_BCD = {4'(LOCK_SECS / 10), 4'(LOCK_SECS % 10)};

    logic [DIV_W-1:0] div_cnt;
    logic             running;
    logic             tick;

    assign tick = running && (div_cnt == DIV_W'(TICK_DIV - 1));

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            div_cnt   <= '0;
            running   <= 1'b0;
            secs_left <= LOCK_BCD;  // idle value, ready for the next lockout
            lock_done <= 1'b0;
        end else begin
            lock_done <= 1'b0;
            if (lock_start) begin
                div_cnt   <= '0;
                running   <= 1'b1;
                secs_left <= LOCK_BCD;
            end else if (running) begin
                div_cnt <= tick ? '0 : div_cnt + 1'b1;
                if (tick) begin
                    if (secs_left[3:0] == 4'd0) begin
                        secs_left <= {secs_left[7:4] - 4'd1, 4'd9};  // borrow from tens
                    end else begin
                        secs_left[3:0] <= secs_left[3:0] - 4'd1;
                    end
                    if (secs_left == 8'h01) begin
                        running   <= 1'b0;  // stops at 00
                        lock_done <= 1'b1;
                    end
                end
            end else if (lock_done) begin
                secs_left <= LOCK_BCD;  // reload once the lock is released
            end
        end
    end

    assert property (@(posedge clk) disable iff (!arst_n)
        secs_left[3:0] <= 4'd9 && secs_left[7:4] <= 4'd9)
        else $error("lockout_timer: countdown left decimal range");

endmodule

// ==== source/buzzer_tone.sv ====
`timescale 1ns/1ps

module buzzer_tone import lock_pkg::*; #(
    parameter int TONE_HALF = 50_000,
    parameter int TONE_LEN  = 10_000_000
) (
    input  logic      clk,
    input  logic      arst_n,
    input  tone_req_t tone,
    output logic      buzzer
);

    localparam int FAST_HALF = (TONE_HALF > 1) ? TONE_HALF / 2 : 1;
    localparam int HALF_W    = $clog2(2 * TONE_HALF + 1);
    localparam int LEN_W     = $clog2(3 * TONE_LEN + 1);

    logic              active;
    tone_kind_e        kind_q;
    logic [HALF_W-1:0] half_cnt;
    logic [LEN_W-1:0]  len_cnt;
    logic              phase;     // square wave before muting
    logic [HALF_W-1:0] half_lim;
    logic [LEN_W-1:0]  dur_lim;
    logic              half_end;
    logic              phase_nxt;
    logic [LEN_W-1:0]  len_nxt;
    logic              mute_nxt;  // silent middle part of the fail tone

    always_comb begin
        case (kind_q)
            TONE_SUCCESS: begin
                half_lim = HALF_W'(FAST_HALF);
                dur_lim  = LEN_W'(3 * TONE_LEN);
            end
            TONE_FAIL: begin
                half_lim = HALF_W'(2 * TONE_HALF);
                dur_lim  = LEN_W'(3 * TONE_LEN);
            end
            default: begin
                half_lim = HALF_W'(TONE_HALF);
                dur_lim  = LEN_W'(TONE_LEN);
            end
        endcase
    end

    assign half_end  = (half_cnt == half_lim - 1'b1);
    assign phase_nxt = half_end ? ~phase : phase;
    assign len_nxt   = len_cnt + 1'b1;
    assign mute_nxt  = (kind_q == TONE_FAIL) && (len_nxt >= LEN_W'(TONE_LEN))
                       && (len_nxt < LEN_W'(2 * TONE_LEN));

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            active   <= 1'b0;
            kind_q   <= TONE_CLICK;
            half_cnt <= '0;
            len_cnt  <= '0;
            phase    <= 1'b0;
            buzzer   <= 1'b0;
        end else if (tone.valid) begin  // new request restarts the tone
            active   <= 1'b1;
            kind_q   <= tone.kind;
            half_cnt <= '0;
            len_cnt  <= '0;
            phase    <= 1'b1;
            buzzer   <= 1'b1;
        end else if (active) begin
            len_cnt  <= len_nxt;
            half_cnt <= half_end ? '0 : half_cnt + 1'b1;
            phase    <= phase_nxt;
            if (len_nxt == dur_lim) begin
                active <= 1'b0;  // duration over
                buzzer <= 1'b0;
            end else begin
                buzzer <= phase_nxt && !mute_nxt;
            end
        end else begin
            buzzer <= 1'b0;
        end
    end

    assert property (@(posedge clk) disable iff (!arst_n)
        !active |-> !buzzer)
        else $error("buzzer_tone: buzzer high with no tone running");

endmodule

// ==== source/code_lock_top.sv ====
`timescale 1ns/1ps

module code_lock_top import lock_pkg::*; #(
    parameter logic [11:0] SECRET    = 12'h246,
    parameter int          MAX_TRIES = 3,
    parameter int          LOCK_SECS = 12,
    parameter int          TICK_DIV  = 50_000_000,
    parameter int          TONE_HALF = 50_000,
    parameter int          TONE_LEN  = 10_000_000
) (
    input  logic             clk,
    input  logic             arst_n,
    input  logic [15:0]      onehot,
    output logic [11:0]      display,
    output lock_state_e      state,
    output logic [TRY_W-1:0] tries,
    output logic             buzzer
);

    key_event_t key;
    tone_req_t  tone;
    logic       lock_start;
    logic       lock_done;
    logic [7:0] secs_left;  // two BCD digits

    key_decoder u_key_decoder (
        .clk    (clk),
        .arst_n (arst_n),
        .onehot (onehot),
        .key    (key)
    );

    code_entry #(
        .SECRET    (SECRET),
        .MAX_TRIES (MAX_TRIES)
    ) u_code_entry (
        .clk        (clk),
        .arst_n     (arst_n),
        .key        (key),
        .secs_left  (secs_left),
        .lock_done  (lock_done),
        .display    (display),
        .state      (state),
        .tries      (tries),
        .lock_start (lock_start),
        .tone       (tone)
    );

    lockout_timer #(
        .LOCK_SECS (LOCK_SECS),
        .TICK_DIV  (TICK_DIV)
    ) u_lockout_timer (
        .clk        (clk),
        .arst_n     (arst_n),
        .lock_start (lock_start),
        .secs_left  (secs_left),
        .lock_done  (lock_done)
    );

    buzzer_tone #(
        .TONE_HALF (TONE_HALF),
        .TONE_LEN  (TONE_LEN)
    ) u_buzzer_tone (
        .clk    (clk),
        .arst_n (arst_n),
        .tone   (tone),
        .buzzer (buzzer)
    );

endmodule

// ==== verif/code_lock_tb.sv ====
`timescale 1ns/1ps

module code_lock_tb import lock_pkg::*; ();

    localparam logic [11:0] SECRET    = 12'h246;
    localparam int          MAX_TRIES = 3;
    localparam int          LOCK_SECS = 12;
    localparam int          TICK_DIV  = 20;
    localparam int          TONE_HALF = 4;
    localparam int          TONE_LEN  = 40;

    localparam int ID_ENTER    = 10;
    localparam int ID_CANCEL   = 11;
    localparam int ID_CLEAR    = 12;
    localparam int N_RANDOM    = 400;
    localparam int MAX_PRESSES = 80 + 4 * N_RANDOM;  // a secret attempt is 4 presses
    localparam int LOCK_CYCLES = LOCK_SECS * TICK_DIV + 10;
    localparam int WATCHDOG_CYCLES = MAX_PRESSES * 20
        + (MAX_PRESSES / ((CODE_DIGITS + 1) * MAX_TRIES) + 1) * LOCK_CYCLES
        + 3 * TONE_LEN + 1000;

    logic             clk = 1'b0;
    logic             arst_n;
    logic [15:0]      onehot;
    logic [11:0]      display;
    lock_state_e      state;
    logic [TRY_W-1:0] tries;
    logic             buzzer;

    integer seed = 32'h256a;
    int     err_display = 0;
    int     err_state = 0;
    int     err_tries = 0;
    int     err_buzzer = 0;
    int     err_cover = 0;
    int     opens = 0;
    int     lockouts = 0;
    int     tens_borrows = 0;

    // reference model state
    logic [15:0] kp_q;
    logic [15:0] kp_prev;
    logic        ev_valid;
    int          ev_id;
    lock_state_e m_state;
    logic [11:0] m_entry;
    int          m_cnt;
    int          m_tries;
    logic        m_start;
    logic        m_done;
    logic        m_run;
    int          m_div;
    int          m_secs;
    logic        m_tone_valid;
    tone_kind_e  m_tone_kind;
    logic [11:0] exp_display;

    // buzzer monitor state
    int          since_tone;
    bit          tone_seen;
    bit          last_long;
    bit          high_seen;
    logic [11:0] last_display;

    code_lock_top #(
        .SECRET    (SECRET),
        .MAX_TRIES (MAX_TRIES),
        .LOCK_SECS (LOCK_SECS),
        .TICK_DIV  (TICK_DIV),
        .TONE_HALF (TONE_HALF),
        .TONE_LEN  (TONE_LEN)
    ) DUT (
        .clk     (clk),
        .arst_n  (arst_n),
        .onehot  (onehot),
        .display (display),
        .state   (state),
        .tries   (tries),
        .buzzer  (buzzer)
    );

    initial begin
        forever #4 clk = ~clk;
    end

    function automatic int urand(input int n);
        return $unsigned($random(seed)) % n;
    endfunction

    // keypad map, ids 0-9 are digits
    function automatic logic [15:0] key_onehot(input int id);
        case (id)
            0: return 16'h0008;
            1: return 16'h0080;
            2: return 16'h0040;
            3: return 16'h0020;
            4: return 16'h0800;
            5: return 16'h0400;
            6: return 16'h0200;
            7: return 16'h8000;
            8: return 16'h4000;
            9: return 16'h2000;
            ID_ENTER:  return 16'h0001;
            ID_CANCEL: return 16'h1000;
            ID_CLEAR:  return 16'h0100;
            default:   return 16'h0000;
        endcase
    endfunction

    function automatic int key_id(input logic [15:0] code);
        for (int i = 0; i <= ID_CLEAR; i++) begin
            if (code == key_onehot(i)) return i;
        end
        return -1;  // release, unused key or chord
    endfunction

    function automatic logic [7:0] to_bcd(input int secs);
        return {4'(secs / 10), 4'(secs % 10)};
    endfunction

    function automatic logic [15:0] illegal_code();
        int pick;
        int a;
        pick = urand(3);
        a = urand(13);
        if (pick == 0) return (a < 4) ? 16'h0002 : ((a < 8) ? 16'h0004 : 16'h0010);
        if (pick == 1) return key_onehot(a) | key_onehot((a + 1 + urand(12)) % 13);  // chord
        return $random(seed);
    endfunction

    task automatic press(input logic [15:0] code, input int hold, input int gap);
        @(posedge clk);
        onehot <= code;
        repeat (hold - 1) @(posedge clk);
        @(posedge clk);
        onehot <= '0;
        repeat (gap - 1) @(posedge clk);
    endtask

    task automatic press_key(input logic [15:0] code);
        press(code, 2 + urand(5), 2 + urand(7));
    endtask

    task automatic enter_code(input int d2, input int d1, input int d0);
        press_key(key_onehot(d2));
        press_key(key_onehot(d1));
        press_key(key_onehot(d0));
        press_key(key_onehot(ID_ENTER));
    endtask

    task automatic run_directed();
        press_key(key_onehot(1));
        press_key(key_onehot(2));
        press_key(key_onehot(ID_ENTER));  // short entry
        press_key(key_onehot(ID_CANCEL));
        press_key(16'h0002);
        press_key(key_onehot(2) | key_onehot(5));
        press(key_onehot(SECRET[11:8]), 6, 3);  // long hold, one event
        press_key(key_onehot(SECRET[7:4]));
        press_key(key_onehot(SECRET[3:0]));
        press_key(key_onehot(7));  // fourth digit
        press_key(key_onehot(ID_ENTER));
        press_key(key_onehot(3));
        press_key(key_onehot(ID_CLEAR));
        enter_code(1, 3, 5);
        press_key(key_onehot(9));
        press_key(key_onehot(ID_CANCEL));  // tries stay at 1
        enter_code(1, 3, 5);
        enter_code(9, 9, 9);
        while (m_state == ST_LOCKED) press_key(key_onehot(urand(13)));
    endtask

    task automatic random_press();
        int pick;
        pick = urand(100);
        if (pick < 10) press_key(illegal_code());
        else if (pick < 18) press_key(key_onehot(ID_ENTER));
        else if (pick < 22) press_key(key_onehot(ID_CANCEL));
        else if (pick < 26) press_key(key_onehot(ID_CLEAR));
        else if (pick < 32) enter_code(SECRET[11:8], SECRET[7:4], SECRET[3:0]);
        else press_key(key_onehot(urand(10)));
    endtask

    always @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            kp_q         <= '0;
            kp_prev      <= '0;
            ev_valid     <= 1'b0;
            ev_id        <= -1;
            m_state      <= ST_ENTRY;
            m_entry      <= 12'hFFF;
            m_cnt        <= 0;
            m_tries      <= 0;
            m_start      <= 1'b0;
            m_done       <= 1'b0;
            m_run        <= 1'b0;
            m_div        <= 0;
            m_secs       <= LOCK_SECS;
            m_tone_valid <= 1'b0;
            m_tone_kind  <= TONE_CLICK;
        end else begin
            kp_q         <= onehot;
            kp_prev      <= kp_q;
            ev_valid     <= (key_id(kp_q) >= 0) && (kp_q != kp_prev);  // fresh legal code
            ev_id        <= key_id(kp_q);
            m_start      <= 1'b0;
            m_done       <= 1'b0;
            m_tone_valid <= 1'b0;
            if (m_start) begin
                m_run  <= 1'b1;
                m_div  <= 0;
                m_secs <= LOCK_SECS;
            end else if (m_run) begin
                if (m_div == TICK_DIV - 1) begin
                    m_div  <= 0;
                    m_secs <= m_secs - 1;
                    if (m_secs == 1) begin
                        m_run  <= 1'b0;
                        m_done <= 1'b1;
                    end
                end else begin
                    m_div <= m_div + 1;
                end
            end else if (m_done) begin
                m_secs <= LOCK_SECS;
            end
            if (m_state == ST_LOCKED) begin
                if (m_done) begin
                    m_state <= ST_ENTRY;
                    m_entry <= 12'hFFF;
                    m_cnt   <= 0;
                end
            end else if (ev_valid && m_state == ST_OPEN) begin
                if (ev_id == ID_CLEAR) begin
                    m_state <= ST_ENTRY;
                    m_entry <= 12'hFFF;
                    m_cnt   <= 0;
                    m_tries <= 0;
                end
            end else if (ev_valid) begin
                if (ev_id <= 9 && m_cnt < CODE_DIGITS) begin
                    m_entry      <= {m_entry[7:0], 4'(ev_id)};
                    m_cnt        <= m_cnt + 1;
                    m_tone_valid <= 1'b1;
                    m_tone_kind  <= TONE_CLICK;
                end else if (ev_id == ID_ENTER && m_cnt == CODE_DIGITS) begin
                    m_cnt        <= 0;
                    m_tone_valid <= 1'b1;
                    if (m_entry == SECRET) begin
                        m_state     <= ST_OPEN;
                        m_entry     <= OPEN_GLYPH;
                        m_tone_kind <= TONE_SUCCESS;
                        opens++;
                    end else begin
                        m_entry     <= 12'hFFF;
                        m_tone_kind <= TONE_FAIL;
                        if (m_tries + 1 == MAX_TRIES) begin
                            m_state <= ST_LOCKED;
                            m_tries <= 0;
                            m_start <= 1'b1;
                            lockouts++;
                        end else begin
                            m_tries <= m_tries + 1;
                        end
                    end
                end else if (ev_id == ID_CANCEL || ev_id == ID_CLEAR) begin
                    m_entry <= 12'hFFF;
                    m_cnt   <= 0;
                    if (ev_id == ID_CLEAR) m_tries <= 0;
                end
            end
        end
    end

    assign exp_display = (m_state == ST_LOCKED) ? {4'h0, to_bcd(m_secs)} : m_entry;

    // outputs compared in the middle of the cycle
    always @(negedge clk) begin
        if (!arst_n) begin
            tone_seen  = 1'b0;
            since_tone = 0;
            if (buzzer !== 1'b0) begin
                err_buzzer++;
                $display("[FAIL] %0t ns: buzzer high during reset", $time);
            end
        end else begin
            if (display !== exp_display) begin
                err_display++;
                $display("[FAIL] %0t ns: display %h, expected %h", $time, display, exp_display);
            end
            if (state !== m_state) begin
                err_state++;
                $display("[FAIL] %0t ns: state %0d, expected %0d", $time, state, m_state);
            end
            if (tries !== TRY_W'(m_tries)) begin
                err_tries++;
                $display("[FAIL] %0t ns: tries %0d, expected %0d", $time, tries, m_tries);
            end
            if (state == ST_LOCKED && last_display == 12'h010 && display == 12'h009)
                tens_borrows++;
            last_display = display;
            if (m_tone_valid) begin
                since_tone = 0;
                tone_seen  = 1'b1;
                high_seen  = 1'b0;
                last_long  = (m_tone_kind != TONE_CLICK);
            end else begin
                since_tone++;
            end
            if (since_tone >= 1 && buzzer) high_seen = 1'b1;
            if (tone_seen && since_tone == 3 && !high_seen) begin
                err_buzzer++;
                $display("[FAIL] %0t ns: buzzer not high within 3 cycles of a tone", $time);
            end
            if (buzzer && (!tone_seen
                    || since_tone >= (last_long ? 3 * TONE_LEN + 2 : TONE_LEN + 2))) begin
                err_buzzer++;
                $display("[FAIL] %0t ns: buzzer high with no tone playing", $time);
            end
        end
    end

    // watchdog
    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Timeout: stimulus still running after %0d cycles", WATCHDOG_CYCLES);
        $display("Simulation failed");
        $finish;
    end

    initial begin
        int total;
        arst_n = 1'b0;
        onehot = '0;
        repeat (8) @(posedge clk);
        arst_n <= 1'b1;
        repeat (2) @(posedge clk);
        run_directed();
        for (int i = 0; i < N_RANDOM; i++) random_press();
        repeat (3 * TONE_LEN + 20) @(posedge clk);  // quiet tail
        if (opens == 0 || lockouts == 0 || tens_borrows == 0) begin
            err_cover++;
            $display("Stimulus missed a case: opens %0d, lockouts %0d, 10 to 09 steps %0d",
                     opens, lockouts, tens_borrows);
        end
        total = err_display + err_state + err_tries + err_buzzer + err_cover;
        $display("Errors: display %0d, state %0d, tries %0d, buzzer %0d, coverage %0d",
                 err_display, err_state, err_tries, err_buzzer, err_cover);
        if (total == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== sim.f ====
source/lock_pkg.sv
source/key_decoder.sv
source/code_entry.sv
source/lockout_timer.sv
source/buzzer_tone.sv
source/code_lock_top.sv
verif/code_lock_tb.sv

// ==== Bender.yml ====
package:
  name: code_lock

sources:
  - source/lock_pkg.sv
  - source/key_decoder.sv
  - source/code_entry.sv
  - source/lockout_timer.sv
  - source/buzzer_tone.sv
  - source/code_lock_top.sv
  - target: test
    files:
      - verif/code_lock_tb.sv
